// ==== compile.f ====
source/eth_rx_pkg.sv
source/unit_packer.sv
source/rmii_frame_receiver.sv
source/ffcp_fgp_parser.sv
source/pixel_writer.sv
source/eth_rx_top.sv
test/eth_rx_properties.sv
test/eth_rx_tb.sv

// ==== Makefile ====
# Verilator build and regression for the Ethernet FFCP receive path

VERILATOR ?= verilator
TOP ?= eth_rx_tb
FILELIST ?= compile.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Regression passed

SOURCES := $(wildcard source/*.sv) $(wildcard test/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/eth_rx_tb.sv ====
// Table-driven testbench with RMII frame driver, reference queues, output monitor and timeout
`default_nettype none
`timescale 1ns/1ps

module eth_rx_tb;

	import eth_rx_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 10;
	localparam int IDLE_CYCLES = 6;
	localparam int CRC_LEN = 4;
	localparam int NO_ABORT = -1;
	localparam int NUM_TESTS = 10;
	// Preamble with SFD, header, type, index, offset, data and filler CRC
	localparam int FRAME_BYTES = 8 + ETH_HEADER_LEN + 3 + FGP_DATA_LEN + CRC_LEN;
	localparam int CYCLE_LIMIT = 2 * (RESET_CYCLES + NUM_TESTS * (4 * FRAME_BYTES + IDLE_CYCLES));

	typedef struct {
		logic [15:0] ethertype;
		ffcp_type_t ptype;
		ffcp_index_t index;
		byte_t offset;
		int abort_pos;
	} test_t;

	logic clk;
	logic eth_rx_downstream_rst;
	logic crs_dv;
	dibit_t rxd;
	logic rx_err;
	logic meta_valid;
	ffcp_type_t meta_type;
	ffcp_index_t meta_index;
	logic vram_we;
	vram_addr_t vram_waddr;
	pixel_t vram_win;

	test_t tests [NUM_TESTS];
	byte_t frame_q [$];
	vram_addr_t exp_addr_q [$];
	pixel_t exp_pixel_q [$];
	ffcp_type_t exp_type_q [$];
	ffcp_index_t exp_index_q [$];
	integer seed;
	int write_errors;
	int meta_errors;
	int other_errors;
	int cycle_cnt;

	eth_rx_top dut (
		.clk(clk),
		.eth_rx_downstream_rst(eth_rx_downstream_rst),
		.crs_dv(crs_dv),
		.rxd(rxd),
		.rx_err(rx_err),
		.meta_valid(meta_valid),
		.meta_type(meta_type),
		.meta_index(meta_index),
		.vram_we(vram_we),
		.vram_waddr(vram_waddr),
		.vram_win(vram_win)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic check_write(input vram_addr_t exp_addr, input pixel_t exp_pixel,
			input vram_addr_t got_addr, input pixel_t got_pixel);
		if (got_addr !== exp_addr || got_pixel !== exp_pixel) begin
			write_errors++;
			$display("ERROR %0t: VRAM write addr %0d data %06h, expected addr %0d data %06h",
				$time, got_addr, got_pixel, exp_addr, exp_pixel);
		end
	endtask

	task automatic check_meta(input ffcp_type_t exp_type, input ffcp_index_t exp_index,
			input ffcp_type_t got_type, input ffcp_index_t got_index);
		if (got_type !== exp_type || got_index !== exp_index) begin
			meta_errors++;
			$display("ERROR %0t: metadata type %0d index %0d, expected type %0d index %0d",
				$time, got_type, got_index, exp_type, exp_index);
		end
	endtask

	task automatic fill_tests();
		tests[0] = '{ETHERTYPE_FFCP, FFCP_TYPE_MSG, 8'h10, 8'd3, NO_ABORT};
		tests[1] = '{ETHERTYPE_FFCP, FFCP_TYPE_SYN, 8'h11, 8'd0, NO_ABORT};
		tests[2] = '{ETHERTYPE_FFCP, FFCP_TYPE_ACK, 8'h12, 8'd0, NO_ABORT};
		// Foreign ethertype and header aborts must leave no trace
		tests[3] = '{16'h0800, FFCP_TYPE_MSG, 8'h13, 8'd5, NO_ABORT};
		tests[4] = '{ETHERTYPE_FFCP, FFCP_TYPE_MSG, 8'h14, 8'd6, 5};
		tests[5] = '{ETHERTYPE_FFCP, FFCP_TYPE_MSG, 8'h15, 8'd9, NO_ABORT};
		tests[6] = '{ETHERTYPE_FFCP, FFCP_TYPE_MSG, 8'h16, 8'd255, NO_ABORT};
		tests[7] = '{ETHERTYPE_FFCP, FFCP_TYPE_MSG, 8'h17, 8'd0, NO_ABORT};
		tests[8] = '{ETHERTYPE_FFCP, FFCP_TYPE_MSG, 8'h18, 8'd128, 12};
		tests[9] = '{ETHERTYPE_FFCP, FFCP_TYPE_MSG, 8'h19, 8'd200, NO_ABORT};
	endtask

	// Builds the byte stream of one frame and queues the results it should produce
	task automatic prepare_frame(input test_t t);
		byte_t data [FGP_DATA_LEN];
		int i;
		frame_q.delete();
		repeat (7) frame_q.push_back(8'h55);
		frame_q.push_back(8'hd5);
		repeat (6) frame_q.push_back(8'hff);
		for (i = 0; i < 6; i++) begin
			frame_q.push_back(byte_t'(8'h02 + i));
		end
		frame_q.push_back(t.ethertype[15:8]);
		frame_q.push_back(t.ethertype[7:0]);
		frame_q.push_back(t.ptype);
		frame_q.push_back(t.index);
		frame_q.push_back(t.offset);
		for (i = 0; i < FGP_DATA_LEN; i++) begin
			data[i] = byte_t'($random(seed));
			frame_q.push_back(data[i]);
		end
		repeat (CRC_LEN) frame_q.push_back(8'ha5);
		if (t.ethertype == ETHERTYPE_FFCP && t.abort_pos == NO_ABORT) begin
			exp_type_q.push_back(t.ptype);
			exp_index_q.push_back(t.index);
			if (t.ptype == FFCP_TYPE_MSG) begin
				for (i = 0; i < FGP_DATA_LEN_COLORS; i++) begin
					exp_addr_q.push_back(vram_addr_t'(int'(t.offset) * FGP_DATA_LEN_COLORS + i));
					exp_pixel_q.push_back({data[3*i+2], data[3*i+1], data[3*i]});
				end
			end
		end
	endtask

	task automatic drive_dibit(input dibit_t d, input logic err);
		@(posedge clk);
		#2;
		crs_dv = 1'b1;
		rxd = d;
		rx_err = err;
	endtask

	task automatic drive_idle();
		@(posedge clk);
		#2;
		crs_dv = 1'b0;
		rxd = '0;
		rx_err = 1'b0;
	endtask

	// Dibits go out least significant first, rx_err covers the whole aborted byte
	task automatic send_frame(input int abort_pos);
		int err_byte;
		int i;
		int d;
		byte_t b;
		err_byte = (abort_pos == NO_ABORT) ? -1 : 8 + abort_pos;
		for (i = 0; i < frame_q.size(); i++) begin
			b = frame_q[i];
			for (d = 0; d < 4; d++) begin
				drive_dibit(b[2*d +: 2], i == err_byte);
			end
		end
		repeat (IDLE_CYCLES) drive_idle();
	endtask

	always @(negedge clk) begin
		if (!eth_rx_downstream_rst && vram_we) begin
			if (exp_addr_q.size() == 0) begin
				other_errors++;
				$display("Unexpected VRAM write at %0t to address %0d", $time, vram_waddr);
			end else begin
				check_write(exp_addr_q.pop_front(), exp_pixel_q.pop_front(), vram_waddr, vram_win);
			end
		end
		if (!eth_rx_downstream_rst && meta_valid) begin
			if (exp_type_q.size() == 0) begin
				other_errors++;
				$display("Unexpected metadata report at %0t with index %0d", $time, meta_index);
			end else begin
				check_meta(exp_type_q.pop_front(), exp_index_q.pop_front(), meta_type, meta_index);
			end
		end
	end

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < CYCLE_LIMIT) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("Timeout after %0d cycles, %0d writes and %0d metadata reports never arrived",
			cycle_cnt, exp_addr_q.size(), exp_type_q.size());
		$display("Errors: write %0d, metadata %0d, other %0d",
			write_errors, meta_errors, other_errors + 1);
		$display("Regression failed");
		$finish;
	end

	initial begin
		int n;
		crs_dv = 1'b0;
		rxd = '0;
		rx_err = 1'b0;
		eth_rx_downstream_rst = 1'b1;
		seed = 32'h544c;
		write_errors = 0;
		meta_errors = 0;
		other_errors = 0;
		fill_tests();
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		eth_rx_downstream_rst = 1'b0;
		for (n = 0; n < NUM_TESTS; n++) begin
			prepare_frame(tests[n]);
			send_frame(tests[n].abort_pos);
		end
		// Drain whatever is still in flight
		while (exp_addr_q.size() != 0 || exp_type_q.size() != 0) begin
			@(posedge clk);
		end
		repeat (IDLE_CYCLES) @(posedge clk);
		$display("Errors: write %0d, metadata %0d, other %0d",
			write_errors, meta_errors, other_errors);
		if (write_errors + meta_errors + other_errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== test/eth_rx_properties.sv ====
// Concurrent assertions on the receive path outputs, bound to eth_rx_top
`default_nettype none
`timescale 1ns/1ps

module eth_rx_properties (
	input logic                    clk,
	input logic                    eth_rx_downstream_rst,
	input logic                    meta_valid,
	input logic                    vram_we,
	input eth_rx_pkg::vram_addr_t  vram_waddr
);

	import eth_rx_pkg::*;

	// Set by a write to the last VRAM word, cleared by the next metadata report
	logic top_written;

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst || meta_valid) begin
			top_written <= 1'b0;
		end else if (vram_we && vram_waddr == vram_addr_t'(VRAM_SIZE - 1)) begin
			top_written <= 1'b1;
		end
	end

	// Strobes are cleared by the first reset edge
	a_quiet_in_reset: assert property (@(posedge clk)
		eth_rx_downstream_rst |=> (!vram_we && !meta_valid))
		else $error("meta_valid or vram_we high while in reset");

	// Another write in the packet after the last word would wrap back to address 0
	a_waddr_in_range: assert property (@(posedge clk) disable iff (eth_rx_downstream_rst)
		vram_we |-> !top_written)
		else $error("VRAM write address ran past the VRAM size");

	a_waddr_known: assert property (@(posedge clk) disable iff (eth_rx_downstream_rst)
		vram_we |-> !$isunknown(vram_waddr))
		else $error("VRAM write address unknown during a write");

endmodule

bind eth_rx_top eth_rx_properties u_properties (
	.clk(clk),
	.eth_rx_downstream_rst(eth_rx_downstream_rst),
	.meta_valid(meta_valid),
	.vram_we(vram_we),
	.vram_waddr(vram_waddr)
);

`default_nettype wire

// ==== source/eth_rx_top.sv ====
// Top level of the RMII to VRAM receive path: frame receiver, FFCP parser, pixel writer
`default_nettype none
`timescale 1ns/1ps

module eth_rx_top (
	input  logic                     clk,
	input  logic                     eth_rx_downstream_rst,
	input  logic                     crs_dv,
	input  eth_rx_pkg::dibit_t       rxd,
	input  logic                     rx_err,
	output logic                     meta_valid,
	output eth_rx_pkg::ffcp_type_t   meta_type,
	output eth_rx_pkg::ffcp_index_t  meta_index,
	output logic                     vram_we,
	output eth_rx_pkg::vram_addr_t   vram_waddr,
	output eth_rx_pkg::pixel_t       vram_win
);

	import eth_rx_pkg::*;

	// Receiver to parser
	logic payload_valid;
	byte_t payload_byte;
	logic payload_end;

	// Parser to pixel writer
	logic offset_valid;
	byte_t offset;
	logic data_valid;
	byte_t data_byte;

	rmii_frame_receiver u_receiver (
		.clk(clk),
		.eth_rx_downstream_rst(eth_rx_downstream_rst),
		.crs_dv(crs_dv),
		.rxd(rxd),
		.rx_err(rx_err),
		.payload_valid(payload_valid),
		.payload_byte(payload_byte),
		.payload_end(payload_end)
	);

	ffcp_fgp_parser u_parser (
		.clk(clk),
		.eth_rx_downstream_rst(eth_rx_downstream_rst),
		.payload_valid(payload_valid),
		.payload_byte(payload_byte),
		.payload_end(payload_end),
		.meta_valid(meta_valid),
		.meta_type(meta_type),
		.meta_index(meta_index),
		.offset_valid(offset_valid),
		.offset(offset),
		.data_valid(data_valid),
		.data_byte(data_byte)
	);

	pixel_writer u_writer (
		.clk(clk),
		.eth_rx_downstream_rst(eth_rx_downstream_rst),
		.offset_valid(offset_valid),
		.offset(offset),
		.data_valid(data_valid),
		.data_byte(data_byte),
		.vram_we(vram_we),
		.vram_waddr(vram_waddr),
		.vram_win(vram_win)
	);

endmodule

`default_nettype wire

// ==== source/pixel_writer.sv ====
// Byte to pixel packing and VRAM write address generation from the FGP offset
`default_nettype none
`timescale 1ns/1ps

module pixel_writer (
	input  logic                    clk,
	input  logic                    eth_rx_downstream_rst,
	input  logic                    offset_valid,
	input  eth_rx_pkg::byte_t       offset,
	input  logic                    data_valid,
	input  eth_rx_pkg::byte_t       data_byte,
	output logic                    vram_we,
	output eth_rx_pkg::vram_addr_t  vram_waddr,
	output eth_rx_pkg::pixel_t      vram_win
);

	import eth_rx_pkg::*;

	vram_addr_t waddr;
	logic pixel_valid;

	// A new offset always starts a fresh pixel
	unit_packer #(
		.in_t(byte_t),
		.out_t(pixel_t)
	) u_pixel_packer (
		.clk(clk),
		.eth_rx_downstream_rst(eth_rx_downstream_rst),
		.restart(offset_valid),
		.in_valid(data_valid),
		.in_unit(data_byte),
		.out_valid(pixel_valid),
		.out_word(vram_win)
	);

	// Packet k covers pixels k*8 to k*8+7
	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			waddr <= '0;
		end else if (offset_valid) begin
			waddr <= vram_addr_t'(offset) * vram_addr_t'(FGP_DATA_LEN_COLORS);
		end else if (pixel_valid) begin
			waddr <= waddr + 1'b1;
		end
	end

	assign vram_we = pixel_valid;
	assign vram_waddr = waddr;

endmodule

`default_nettype wire

// ==== source/ffcp_fgp_parser.sv ====
// FFCP header parser reporting type and index, and FGP offset and data splitter
`default_nettype none
`timescale 1ns/1ps

module ffcp_fgp_parser (
	input  logic                     clk,
	input  logic                     eth_rx_downstream_rst,
	input  logic                     payload_valid,
	input  eth_rx_pkg::byte_t        payload_byte,
	input  logic                     payload_end,
	output logic                     meta_valid,
	output eth_rx_pkg::ffcp_type_t   meta_type,
	output eth_rx_pkg::ffcp_index_t  meta_index,
	output logic                     offset_valid,
	output eth_rx_pkg::byte_t        offset,
	output logic                     data_valid,
	output eth_rx_pkg::byte_t        data_byte
);

	import eth_rx_pkg::*;

	// Position of the current byte inside the FFCP payload, saturates past the data
	logic [PAYLOAD_CNT_LEN-1:0] cnt;
	logic msg_pkt;
	logic at_type;
	logic at_index;
	logic at_offset;
	logic at_data;

	assign msg_pkt = meta_type == FFCP_TYPE_MSG;
	assign at_type = cnt == '0;
	assign at_index = cnt == PAYLOAD_CNT_LEN'(1);
	assign at_offset = cnt == PAYLOAD_CNT_LEN'(FGP_OFFSET_POS);
	assign at_data = cnt > PAYLOAD_CNT_LEN'(FGP_OFFSET_POS)
		&& cnt < PAYLOAD_CNT_LEN'(FGP_DATA_END);

	// Field registers, held until the next frame overwrites them
	always_ff @(posedge clk) begin
		if (payload_valid && !payload_end) begin
			if (at_type) begin
				meta_type <= payload_byte;
			end
			if (at_index) begin
				meta_index <= payload_byte;
			end
			if (at_offset) begin
				offset <= payload_byte;
			end
			if (at_data) begin
				data_byte <= payload_byte;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			cnt <= '0;
			meta_valid <= 1'b0;
			offset_valid <= 1'b0;
			data_valid <= 1'b0;
		end else begin
			meta_valid <= 1'b0;
			offset_valid <= 1'b0;
			data_valid <= 1'b0;
			if (payload_end) begin
				cnt <= '0;
			end else if (payload_valid) begin
				if (cnt != PAYLOAD_CNT_LEN'(FGP_DATA_END)) begin
					cnt <= cnt + 1'b1;
				end
				meta_valid <= at_index;
				// Only message packets carry FGP content
				offset_valid <= at_offset && msg_pkt;
				data_valid <= at_data && msg_pkt;
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/rmii_frame_receiver.sv ====
// RMII receive front end with preamble and SFD detection, byte assembly and ethertype filter
`default_nettype none
`timescale 1ns/1ps

module rmii_frame_receiver (
	input  logic                clk,
	input  logic                eth_rx_downstream_rst,
	input  logic                crs_dv,
	input  eth_rx_pkg::dibit_t  rxd,
	input  logic                rx_err,
	output logic                payload_valid,
	output eth_rx_pkg::byte_t   payload_byte,
	output logic                payload_end
);

	import eth_rx_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE,
		S_PREAMBLE,
		S_HEADER,
		S_PAYLOAD,
		S_DISCARD
	} state_t;

	state_t state;

	// PHY inputs are registered once before any decision
	logic crs_dv_q;
	logic rx_err_q;
	dibit_t rxd_q;

	logic [HEADER_CNT_LEN-1:0] hdr_cnt;
	byte_t ethertype_hi;

	logic pk_restart;
	logic pk_in_valid;
	logic byte_valid;
	byte_t rx_byte;

	assign pk_restart = state == S_PREAMBLE && crs_dv_q && rxd_q == SFD_DIBIT;
	assign pk_in_valid = crs_dv_q && !rx_err_q && (state == S_HEADER || state == S_PAYLOAD);

	unit_packer #(
		.in_t(dibit_t),
		.out_t(byte_t)
	) u_dibit_packer (
		.clk(clk),
		.eth_rx_downstream_rst(eth_rx_downstream_rst),
		.restart(pk_restart),
		.in_valid(pk_in_valid),
		.in_unit(rxd_q),
		.out_valid(byte_valid),
		.out_word(rx_byte)
	);

	always_ff @(posedge clk) begin
		rxd_q <= rxd;
	end

	always_ff @(posedge clk) begin
		if (state == S_HEADER && byte_valid && hdr_cnt == HEADER_CNT_LEN'(ETH_HEADER_LEN - 2)) begin
			ethertype_hi <= rx_byte;
		end
		if (state == S_PAYLOAD && byte_valid) begin
			payload_byte <= rx_byte;
		end
	end

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			crs_dv_q <= 1'b0;
			rx_err_q <= 1'b0;
			state <= S_IDLE;
			hdr_cnt <= '0;
			payload_valid <= 1'b0;
			payload_end <= 1'b0;
		end else begin
			crs_dv_q <= crs_dv;
			rx_err_q <= rx_err;
			payload_valid <= 1'b0;
			payload_end <= 1'b0;
			case (state)
				S_IDLE: begin
					// PHY may show zero dibits before the preamble starts
					if (crs_dv_q && rxd_q == PREAMBLE_DIBIT) begin
						state <= S_PREAMBLE;
					end else if (crs_dv_q && rxd_q != '0) begin
						state <= S_DISCARD;
					end
				end
				S_PREAMBLE: begin
					if (!crs_dv_q) begin
						state <= S_IDLE;
					end else if (rxd_q == SFD_DIBIT) begin
						state <= S_HEADER;
						hdr_cnt <= '0;
					end else if (rxd_q != PREAMBLE_DIBIT) begin
						state <= S_DISCARD;
					end
				end
				S_HEADER: begin
					if (!crs_dv_q) begin
						state <= S_IDLE;
					end else if (rx_err_q) begin
						state <= S_DISCARD;
					end else if (byte_valid) begin
						hdr_cnt <= hdr_cnt + 1'b1;
						// Ethertype low byte closes the header
						if (hdr_cnt == HEADER_CNT_LEN'(ETH_HEADER_LEN - 1)) begin
							if ({ethertype_hi, rx_byte} == ETHERTYPE_FFCP) begin
								state <= S_PAYLOAD;
							end else begin
								state <= S_DISCARD;
							end
						end
					end
				end
				S_PAYLOAD: begin
					payload_valid <= byte_valid;
					if (!crs_dv_q || rx_err_q) begin
						payload_end <= 1'b1;
						state <= crs_dv_q ? S_DISCARD : S_IDLE;
					end
				end
				S_DISCARD: begin
					if (!crs_dv_q) begin
						state <= S_IDLE;
					end
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== source/unit_packer.sv ====
// Type-parameterized packer that gathers narrow units into one wide word, LSB unit first
`default_nettype none
`timescale 1ns/1ps

module unit_packer #(
	parameter type in_t = eth_rx_pkg::dibit_t,
	parameter type out_t = eth_rx_pkg::byte_t
) (
	input  logic clk,
	input  logic eth_rx_downstream_rst,
	input  logic restart,
	input  logic in_valid,
	input  in_t  in_unit,
	output logic out_valid,
	output out_t out_word
);

	localparam int IN_LEN = $bits(in_t);
	localparam int OUT_LEN = $bits(out_t);
	localparam int RATIO = OUT_LEN / IN_LEN;
	localparam int CNT_LEN = $clog2(RATIO);

	logic [CNT_LEN-1:0] cnt;
	logic [OUT_LEN-1:0] shift;
	logic last_unit;

	assign last_unit = cnt == CNT_LEN'(RATIO - 1);

	// New units enter at the top, so the first one ends up in the low bits
	always_ff @(posedge clk) begin
		if (in_valid) begin
			shift <= {in_unit, shift[OUT_LEN-1:IN_LEN]};
		end
	end

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			cnt <= '0;
			out_valid <= 1'b0;
		end else begin
			out_valid <= !restart && in_valid && last_unit;
			if (restart) begin
				cnt <= '0;
			end else if (in_valid) begin
				cnt <= last_unit ? '0 : cnt + 1'b1;
			end
		end
	end

	// Word is only meaningful while out_valid is high
	assign out_word = out_t'(shift);

endmodule

`default_nettype wire

// ==== source/eth_rx_pkg.sv ====
// Frame constants, field types and derived widths for the Ethernet FFCP receive path
`default_nettype none

package eth_rx_pkg;

	// Basic units
	localparam int BYTE_LEN = 8;
	localparam int DIBIT_LEN = 2;
	localparam int PIXEL_BYTES = 3;

	typedef logic [DIBIT_LEN-1:0] dibit_t;
	typedef logic [BYTE_LEN-1:0] byte_t;
	typedef logic [PIXEL_BYTES*BYTE_LEN-1:0] pixel_t;

	// Ethernet framing
	localparam int ETH_HEADER_LEN = 14;
	localparam logic [2*BYTE_LEN-1:0] ETHERTYPE_FFCP = 16'h8801;
	localparam dibit_t PREAMBLE_DIBIT = 2'b01;
	localparam dibit_t SFD_DIBIT = 2'b11;
	localparam int HEADER_CNT_LEN = $clog2(ETH_HEADER_LEN);

	// FFCP header fields
	typedef logic [BYTE_LEN-1:0] ffcp_type_t;
	typedef logic [BYTE_LEN-1:0] ffcp_index_t;

	localparam ffcp_type_t FFCP_TYPE_SYN = 8'd1;
	localparam ffcp_type_t FFCP_TYPE_MSG = 8'd2;
	localparam ffcp_type_t FFCP_TYPE_ACK = 8'd3;

	// FGP layout inside an FFCP payload, after type and index
	localparam int FGP_DATA_LEN_COLORS = 8;
	localparam int FGP_DATA_LEN = FGP_DATA_LEN_COLORS * PIXEL_BYTES;
	localparam int FGP_OFFSET_POS = 2;
	localparam int FGP_DATA_END = FGP_OFFSET_POS + 1 + FGP_DATA_LEN;
	localparam int PAYLOAD_CNT_LEN = $clog2(FGP_DATA_END + 1);

	// Video RAM write port
	localparam int VRAM_SIZE = 2048;

	typedef logic [$clog2(VRAM_SIZE)-1:0] vram_addr_t;

endpackage

`default_nettype wire
